// ==== Bender.yml ====
package:
  name: pipe_cpu

sources:
  - src/cpuPkg.sv
  - src/cpuAlu.sv
  - src/regFile.sv
  - src/dataMem.sv
  - src/pipeDatapath.sv
  - src/cpuControl.sv
  - src/pipeCpu.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/pipeCpuTb.sv

// ==== src/cpuAlu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational ALU with N, Z, C and V flags. C and V only
// carry meaning for add and subtract.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cpuAlu (
	input  cpuPkg::aluOpT                 aluCtl,
	input  logic [cpuPkg::dataWidth-1:0]  busA,
	input  logic [cpuPkg::dataWidth-1:0]  busB,
	output logic [cpuPkg::dataWidth-1:0]  result,
	output logic                          cFlag,
	output logic                          nFlag,
	output logic                          vFlag,
	output logic                          zFlag
);
	import cpuPkg::*;

	logic [dataWidth:0] addFull, subFull;
	logic addOverflow, subOverflow;

	assign addFull = {1'b0, busA} + {1'b0, busB};
	// Subtract as A plus inverted B plus one, carry out set means no borrow
	assign subFull = {1'b0, busA} + {1'b0, ~busB} + 1'b1;

	assign addOverflow = (busA[dataWidth-1] == busB[dataWidth-1])
		&& (addFull[dataWidth-1] != busA[dataWidth-1]);
	assign subOverflow = (busA[dataWidth-1] != busB[dataWidth-1])
		&& (subFull[dataWidth-1] != busA[dataWidth-1]);

	always_comb begin
		cFlag = 1'b0;
		vFlag = 1'b0;
		case (aluCtl)
			aluAdd: begin
				result = addFull[dataWidth-1:0];
				cFlag  = addFull[dataWidth];
				vFlag  = addOverflow;
			end
			aluSub: begin
				result = subFull[dataWidth-1:0];
				cFlag  = subFull[dataWidth];
				vFlag  = subOverflow;
			end
			aluAnd: result = busA & busB;
			aluOr:  result = busA | busB;
			aluXor: result = busA ^ busB;
			// Signed less-than is N xor V of the difference
			aluSlt: result = {{(dataWidth-1){1'b0}}, subFull[dataWidth-1] ^ subOverflow};
			default: result = busB;
		endcase
	end

	assign nFlag = result[dataWidth-1];
	assign zFlag = (result == '0);

endmodule

// ==== src/cpuControl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage and decoder: program counter, loadable
// instruction memory, instruction register, squash and halt.
// Decode outputs feed the datapath in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cpuControl #(
	parameter int imemAddrWidth = 8
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             progWrite,
	input  logic [imemAddrWidth-1:0]         progAddr,
	input  logic [cpuPkg::dataWidth-1:0]     progData,
	input  logic                             doBranch,
	input  logic [imemAddrWidth-1:0]         branchTarget,
	output logic [cpuPkg::regAddrWidth-1:0]  decodeRfRdAdrx0,
	output logic [cpuPkg::regAddrWidth-1:0]  decodeRfRdAdrx1,
	output logic [cpuPkg::regAddrWidth-1:0]  decodeRfWrAdrx,
	output logic                             decodeRfWriteEn,
	output cpuPkg::aluOpT                    decodeAluCtl,
	output logic                             decodeAluBusBSel,
	output logic [cpuPkg::dataWidth-1:0]     decodeImmediate,
	output logic                             decodeDmemResultSel,
	output logic                             decodeDmemWrite,
	output cpuPkg::branchOpT                 decodeBranchOp,
	output logic                             decodeValid,
	output logic [imemAddrWidth-1:0]         decodePc,
	output logic                             halted
);
	import cpuPkg::*;

	logic [dataWidth-1:0] imem [0:(1 << imemAddrWidth)-1];
	logic [imemAddrWidth-1:0] pc;
	logic [dataWidth-1:0] instrReg;
	opcodeT decodeOp;
	logic decodeHalt;

	// Program port only writes while the core is held in reset
	always_ff @(posedge clk) begin
		if (reset && progWrite) begin
			imem[progAddr] <= progData;
		end
	end

	// Instruction register and its address follow the PC every cycle
	always_ff @(posedge clk) begin
		instrReg <= imem[pc];
		decodePc <= pc;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc          <= '0;
			decodeValid <= 1'b0;
			halted      <= 1'b0;
		end else begin
			if (decodeHalt) begin
				halted <= 1'b1;
			end
			if (doBranch) begin
				pc <= branchTarget;
			end else if (!halted) begin
				pc <= pc + 1'b1;
			end
			// Taken branch squashes the slot behind it, halt stops all issue
			decodeValid <= !(doBranch || decodeHalt || halted);
		end
	end

	assign decodeOp   = opcodeT'(instrReg[15:12]);
	assign decodeHalt = decodeValid && (decodeOp == opHalt);

	always_comb begin
		decodeRfRdAdrx0     = instrReg[8:6];
		decodeRfRdAdrx1     = instrReg[5:3];
		decodeRfWrAdrx      = instrReg[11:9];
		decodeRfWriteEn     = 1'b0;
		decodeAluCtl        = aluPassB;
		decodeAluBusBSel    = 1'b0;
		decodeImmediate     = {{(dataWidth-6){instrReg[5]}}, instrReg[5:0]};
		decodeDmemResultSel = 1'b0;
		decodeDmemWrite     = 1'b0;
		decodeBranchOp      = brNone;
		case (decodeOp)
			opAdd, opSub, opAnd, opOr, opXor, opSlt: begin
				decodeRfWriteEn = 1'b1;
				case (decodeOp)
					opAdd:   decodeAluCtl = aluAdd;
					opSub:   decodeAluCtl = aluSub;
					opAnd:   decodeAluCtl = aluAnd;
					opOr:    decodeAluCtl = aluOr;
					opXor:   decodeAluCtl = aluXor;
					default: decodeAluCtl = aluSlt;
				endcase
			end
			opAddi: begin
				decodeRfWriteEn  = 1'b1;
				decodeAluCtl     = aluAdd;
				decodeAluBusBSel = 1'b1;
			end
			opLoad: begin
				decodeRfWriteEn     = 1'b1;
				decodeAluCtl        = aluAdd;
				decodeAluBusBSel    = 1'b1;
				decodeDmemResultSel = 1'b1;
			end
			opStore: begin
				// Store data comes from the register named in the rd field
				decodeRfRdAdrx1  = instrReg[11:9];
				decodeAluCtl     = aluAdd;
				decodeAluBusBSel = 1'b1;
				decodeDmemWrite  = 1'b1;
			end
			opBz:  decodeBranchOp = brZero;
			opBnz: decodeBranchOp = brNonZero;
			opJmp: begin
				decodeBranchOp  = brJump;
				decodeImmediate = {{(dataWidth-12){instrReg[11]}}, instrReg[11:0]};
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== src/cpuPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths and encodings of the 16-bit pipelined core.
// Modules import it; the testbench builds programs from the
// opcode values defined here.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpuPkg;

	// Register, instruction and data word width
	localparam int dataWidth = 16;

	// Eight registers
	localparam int regAddrWidth = 3;

	// Instruction formats, bit 15 on the left
	//   register:  op[15:12] rd[11:9] rs[8:6] rt[5:3]
	//   immediate: op[15:12] rd[11:9] rs[8:6] imm[5:0]
	//   jump:      op[15:12] offset[11:0]
	typedef enum logic [3:0] {
		opAdd   = 4'h0,
		opSub   = 4'h1,
		opAnd   = 4'h2,
		opOr    = 4'h3,
		opXor   = 4'h4,
		opSlt   = 4'h5,
		opAddi  = 4'h6,
		opLoad  = 4'h7,
		opStore = 4'h8,
		opBz    = 4'h9,
		opBnz   = 4'hA,
		opJmp   = 4'hB,
		opHalt  = 4'hC
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluAnd   = 3'd2,
		aluOr    = 3'd3,
		aluXor   = 3'd4,
		aluSlt   = 3'd5,
		aluPassB = 3'd6
	} aluOpT;

	// Branch kind carried from decode into execute
	typedef enum logic [1:0] {
		brNone    = 2'd0,
		brZero    = 2'd1,
		brNonZero = 2'd2,
		brJump    = 2'd3
	} branchOpT;

endpackage

// ==== src/dataMem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data RAM with clocked write and registered read. Read data
// appears the cycle after the address is presented.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dataMem #(
	parameter int dmemAddrWidth = 8
) (
	input  logic                          clk,
	input  logic [dmemAddrWidth-1:0]      adrx,
	input  logic [cpuPkg::dataWidth-1:0]  dataIn,
	input  logic                          write,
	output logic [cpuPkg::dataWidth-1:0]  dataOut
);
	import cpuPkg::*;

	logic [dataWidth-1:0] mem [0:(1 << dmemAddrWidth)-1];

	always_ff @(posedge clk) begin
		if (write) begin
			mem[adrx] <= dataIn;
		end
		// Old contents are returned on a same-address write
		dataOut <= mem[adrx];
	end

endmodule

// ==== src/pipeCpu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the three-stage core. Load a program through
// the prog port while reset is high, then watch the store
// port and the halted level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module pipeCpu #(
	parameter int imemAddrWidth = 8,
	parameter int dmemAddrWidth = 8
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          progWrite,
	input  logic [imemAddrWidth-1:0]      progAddr,
	input  logic [cpuPkg::dataWidth-1:0]  progData,
	output logic                          storeValid,
	output logic [dmemAddrWidth-1:0]      storeAddr,
	output logic [cpuPkg::dataWidth-1:0]  storeData,
	output logic                          halted
);
	import cpuPkg::*;

	logic [regAddrWidth-1:0] decodeRfRdAdrx0, decodeRfRdAdrx1, decodeRfWrAdrx;
	logic decodeRfWriteEn, decodeAluBusBSel, decodeDmemResultSel, decodeDmemWrite;
	logic decodeValid;
	aluOpT decodeAluCtl;
	branchOpT decodeBranchOp;
	logic [dataWidth-1:0] decodeImmediate;
	logic [imemAddrWidth-1:0] decodePc, branchTarget;
	logic doBranch;
	logic [dmemAddrWidth-1:0] execDmemAdrx;
	logic [dataWidth-1:0] execDmemDataIn, dmemOutput;
	logic execDmemWrite;

	// Fetch and decode
	cpuControl #(
		.imemAddrWidth(imemAddrWidth)
	) u_cpuControl (
		.clk(clk),
		.reset(reset),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.doBranch(doBranch),
		.branchTarget(branchTarget),
		.decodeRfRdAdrx0(decodeRfRdAdrx0),
		.decodeRfRdAdrx1(decodeRfRdAdrx1),
		.decodeRfWrAdrx(decodeRfWrAdrx),
		.decodeRfWriteEn(decodeRfWriteEn),
		.decodeAluCtl(decodeAluCtl),
		.decodeAluBusBSel(decodeAluBusBSel),
		.decodeImmediate(decodeImmediate),
		.decodeDmemResultSel(decodeDmemResultSel),
		.decodeDmemWrite(decodeDmemWrite),
		.decodeBranchOp(decodeBranchOp),
		.decodeValid(decodeValid),
		.decodePc(decodePc),
		.halted(halted)
	);

	// Execute and writeback
	pipeDatapath #(
		.imemAddrWidth(imemAddrWidth),
		.dmemAddrWidth(dmemAddrWidth)
	) u_pipeDatapath (
		.clk(clk),
		.reset(reset),
		.decodeRfRdAdrx0(decodeRfRdAdrx0),
		.decodeRfRdAdrx1(decodeRfRdAdrx1),
		.decodeRfWrAdrx(decodeRfWrAdrx),
		.decodeRfWriteEn(decodeRfWriteEn),
		.decodeAluCtl(decodeAluCtl),
		.decodeAluBusBSel(decodeAluBusBSel),
		.decodeImmediate(decodeImmediate),
		.decodeDmemResultSel(decodeDmemResultSel),
		.decodeDmemWrite(decodeDmemWrite),
		.decodeBranchOp(decodeBranchOp),
		.decodeValid(decodeValid),
		.decodePc(decodePc),
		.dmemOutput(dmemOutput),
		.doBranch(doBranch),
		.branchTarget(branchTarget),
		.execDmemAdrx(execDmemAdrx),
		.execDmemDataIn(execDmemDataIn),
		.execDmemWrite(execDmemWrite)
	);

	dataMem #(
		.dmemAddrWidth(dmemAddrWidth)
	) u_dataMem (
		.clk(clk),
		.adrx(execDmemAdrx),
		.dataIn(execDmemDataIn),
		.write(execDmemWrite),
		.dataOut(dmemOutput)
	);

	// Every executed store shows up on the store port
	assign storeValid = execDmemWrite;
	assign storeAddr  = execDmemAdrx;
	assign storeData  = execDmemDataIn;

endmodule

// ==== src/pipeDatapath.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute and writeback stages: register read with writeback
// forwarding, ALU, memory address, branch decision and the
// writeback registers.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module pipeDatapath #(
	parameter int imemAddrWidth = 8,
	parameter int dmemAddrWidth = 8
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [cpuPkg::regAddrWidth-1:0]  decodeRfRdAdrx0,
	input  logic [cpuPkg::regAddrWidth-1:0]  decodeRfRdAdrx1,
	input  logic [cpuPkg::regAddrWidth-1:0]  decodeRfWrAdrx,
	input  logic                             decodeRfWriteEn,
	input  cpuPkg::aluOpT                    decodeAluCtl,
	input  logic                             decodeAluBusBSel,
	input  logic [cpuPkg::dataWidth-1:0]     decodeImmediate,
	input  logic                             decodeDmemResultSel,
	input  logic                             decodeDmemWrite,
	input  cpuPkg::branchOpT                 decodeBranchOp,
	input  logic                             decodeValid,
	input  logic [imemAddrWidth-1:0]         decodePc,
	input  logic [cpuPkg::dataWidth-1:0]     dmemOutput,
	output logic                             doBranch,
	output logic [imemAddrWidth-1:0]         branchTarget,
	output logic [dmemAddrWidth-1:0]         execDmemAdrx,
	output logic [cpuPkg::dataWidth-1:0]     execDmemDataIn,
	output logic                             execDmemWrite
);
	import cpuPkg::*;

	logic [dataWidth-1:0] rfData0, rfData1;
	logic [dataWidth-1:0] execOperand0, execOperand1, execBusB, execAluResult;
	logic execTaken;
	logic [regAddrWidth-1:0] wbDest;
	logic wbWrEn, wbLoadSel;
	logic [dataWidth-1:0] wbAluResult, wbData;

	regFile u_regFile (
		.clk(clk),
		.reset(reset),
		.rdAdrx0(decodeRfRdAdrx0),
		.rdAdrx1(decodeRfRdAdrx1),
		.wrAdrx(wbDest),
		.wrEn(wbWrEn),
		.wrData(wbData),
		.rdData0(rfData0),
		.rdData1(rfData1)
	);

	// Writeback result bypasses the register file, register 0 never matches
	assign execOperand0 = (wbWrEn && wbDest == decodeRfRdAdrx0 && decodeRfRdAdrx0 != '0)
		? wbData : rfData0;
	assign execOperand1 = (wbWrEn && wbDest == decodeRfRdAdrx1 && decodeRfRdAdrx1 != '0)
		? wbData : rfData1;

	assign execBusB = decodeAluBusBSel ? decodeImmediate : execOperand1;

	cpuAlu u_cpuAlu (
		.aluCtl(decodeAluCtl),
		.busA(execOperand0),
		.busB(execBusB),
		.result(execAluResult),
		.cFlag(),
		.nFlag(),
		.vFlag(),
		.zFlag()
	);

	always_comb begin
		case (decodeBranchOp)
			brZero:    execTaken = (execOperand0 == '0);
			brNonZero: execTaken = (execOperand0 != '0);
			brJump:    execTaken = 1'b1;
			default:   execTaken = 1'b0;
		endcase
	end

	assign doBranch     = decodeValid && execTaken;
	// Target is relative to the instruction after the branch
	assign branchTarget = decodePc + 1'b1 + decodeImmediate[imemAddrWidth-1:0];

	assign execDmemAdrx   = execAluResult[dmemAddrWidth-1:0];
	assign execDmemDataIn = execOperand1;
	assign execDmemWrite  = decodeValid && decodeDmemWrite;

	always_ff @(posedge clk) begin
		if (reset) begin
			wbWrEn <= 1'b0;
		end else begin
			wbWrEn <= decodeValid && decodeRfWriteEn;
		end
	end

	always_ff @(posedge clk) begin
		wbDest      <= decodeRfWrAdrx;
		wbAluResult <= execAluResult;
		wbLoadSel   <= decodeDmemResultSel;
	end

	// Load data arrives from the RAM one cycle after the address
	assign wbData = wbLoadSel ? dmemOutput : wbAluResult;

endmodule

// ==== src/regFile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight-entry register file, two combinational read ports and
// one clocked write port. Register 0 is hardwired to zero.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module regFile (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [cpuPkg::regAddrWidth-1:0]  rdAdrx0,
	input  logic [cpuPkg::regAddrWidth-1:0]  rdAdrx1,
	input  logic [cpuPkg::regAddrWidth-1:0]  wrAdrx,
	input  logic                             wrEn,
	input  logic [cpuPkg::dataWidth-1:0]     wrData,
	output logic [cpuPkg::dataWidth-1:0]     rdData0,
	output logic [cpuPkg::dataWidth-1:0]     rdData1
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [0:(1 << regAddrWidth)-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < (1 << regAddrWidth); i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAdrx != '0) begin
			regs[wrAdrx] <= wrData;
		end
	end

	assign rdData0 = (rdAdrx0 == '0) ? '0 : regs[rdAdrx0];
	assign rdData1 = (rdAdrx1 == '0) ? '0 : regs[rdAdrx1];

endmodule

// ==== verification/cpuTestTable.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Test programs for the pipelined core and the ordered stores
// each one must make. Included in the testbench module body.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef cpuTestTableSvh
`define cpuTestTableSvh

localparam int numTests = 6;
localparam int romWords = 53;
localparam int romStores = 16;

string testName [0:numTests-1];
int progLen [0:numTests-1];
int storeNum [0:numTests-1];
// Extra cycles spent in loops, iterations times four
int loopCycles [0:numTests-1];
logic [15:0] progRom [0:romWords-1];
// Expected store as {address, data}
logic [23:0] storeRom [0:romStores-1];

function automatic logic [15:0] regOp(input opcodeT op, input int rd, input int rs, input int rt);
	return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
endfunction

function automatic logic [15:0] immOp(input opcodeT op, input int rd, input int rs, input int imm);
	return {op, rd[2:0], rs[2:0], imm[5:0]};
endfunction

function automatic logic [15:0] jumpOp(input int offset);
	return {opJmp, offset[11:0]};
endfunction

function automatic logic [15:0] haltOp();
	return {opHalt, 12'h000};
endfunction

// Programs lie back to back in progRom, stores likewise in storeRom
task automatic buildTestTable();
	testName = '{"aluChain", "immediates", "memRoundTrip", "branches", "sumLoop", "haltRestart"};
	progLen = '{17, 7, 7, 10, 9, 3};
	storeNum = '{7, 3, 2, 2, 1, 1};
	loopCycles = '{0, 0, 0, 0, 40, 0};
	progRom = '{
		// Forwarded chain through every ALU op, then r0 written and stored
		immOp(opAddi, 1, 0, 12), immOp(opAddi, 2, 1, -7), regOp(opAdd, 3, 2, 1),
		regOp(opSub, 4, 2, 3), regOp(opAnd, 5, 4, 3), regOp(opOr, 6, 5, 2),
		regOp(opXor, 7, 6, 4), regOp(opSlt, 1, 7, 6), regOp(opAdd, 0, 1, 3),
		immOp(opStore, 0, 0, 0), immOp(opStore, 3, 0, 1), immOp(opStore, 4, 0, 2),
		immOp(opStore, 5, 0, 3), immOp(opStore, 6, 0, 4), immOp(opStore, 7, 0, 5),
		immOp(opStore, 1, 0, 6), haltOp(),
		// Immediate extremes and a negative store offset
		immOp(opAddi, 1, 0, 31), immOp(opAddi, 2, 1, -32), immOp(opAddi, 3, 2, -32),
		immOp(opStore, 1, 0, 16), immOp(opStore, 2, 0, 17), immOp(opStore, 3, 1, -2),
		haltOp(),
		// Store, load back, use the load at once
		immOp(opAddi, 1, 0, 25), immOp(opAddi, 2, 0, 20), immOp(opStore, 1, 2, 3),
		immOp(opLoad, 3, 2, 3), immOp(opAddi, 4, 3, 7), immOp(opStore, 4, 0, 8),
		haltOp(),
		// Stores at 30 and 31 sit in squashed slots
		immOp(opAddi, 7, 0, -1), immOp(opBz, 0, 0, 1), immOp(opStore, 7, 0, 30),
		immOp(opBz, 0, 7, 1), immOp(opStore, 7, 0, 1), immOp(opAddi, 2, 0, 3),
		immOp(opBnz, 0, 2, 1), immOp(opStore, 7, 0, 31), immOp(opStore, 2, 0, 2),
		haltOp(),
		// Sum of 1 to 10, the store after the halt never runs
		immOp(opAddi, 1, 0, 10), immOp(opAddi, 2, 0, 0), jumpOp(2),
		regOp(opAdd, 2, 2, 1), immOp(opAddi, 1, 1, -1), immOp(opBnz, 0, 1, -3),
		immOp(opStore, 2, 0, 30), haltOp(), immOp(opStore, 2, 0, 31),
		immOp(opAddi, 1, 0, 9), immOp(opStore, 1, 0, 0), haltOp()
	};
	storeRom = '{
		24'h000000, 24'h010011, 24'h02FFF4, 24'h030010, 24'h040015, 24'h05FFE1, 24'h060001,
		24'h10001F, 24'h11FFFF, 24'h1DFFDF,
		24'h170019, 24'h080020,
		24'h01FFFF, 24'h020003,
		24'h1E0037,
		24'h000009
	};
endtask

`endif

// ==== verification/pipeCpuTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the pipelined core. Each table program is loaded
// during reset, then its stores are checked in order until halt.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module pipeCpuTb;
	import cpuPkg::*;

	localparam int resetCycles = 10;

	logic clk = 1'b0;
	logic reset;
	logic progWrite;
	logic [7:0] progAddr;
	logic [15:0] progData;
	logic storeValid;
	logic [7:0] storeAddr;
	logic [15:0] storeData;
	logic halted;

	string currentTest = "none";
	int cycleCount = 0;
	int cycleLimit = 0;

	`include "cpuTestTable.svh"

	pipeCpu #(
		.imemAddrWidth(8),
		.dmemAddrWidth(8)
	) u_pipeCpu (
		.clk(clk),
		.reset(reset),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.halted(halted)
	);

	always #50 clk = ~clk;

	task automatic stopWithError(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			stopWithError($sformatf("mismatch in test %s, %s: expected %0h, actual %0h",
				currentTest, what, expected, actual));
		end
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			stopWithError($sformatf("timeout after %0d cycles, test %s never halted",
				cycleCount, currentTest));
		end
	end

	task automatic runTest(input int t, input int romBase, input int storeBase);
		int seen;
		int holdCycles;
		currentTest = testName[t];
		holdCycles = (progLen[t] > resetCycles) ? progLen[t] : resetCycles;
		// Program words go in while reset is held
		for (int i = 0; i < holdCycles; i++) begin
			@(posedge clk);
			#5;
			reset = 1'b1;
			progWrite = (i < progLen[t]);
			progAddr = i[7:0];
			progData = (i < progLen[t]) ? progRom[romBase + i] : '0;
		end
		@(posedge clk);
		#5;
		reset = 1'b0;
		progWrite = 1'b0;
		seen = 0;
		@(negedge clk);
		checkValue("halted after reset", 0, halted);
		while (!halted) begin
			if (storeValid) begin
				if (seen >= storeNum[t]) begin
					stopWithError($sformatf("test %s made more stores than expected",
						currentTest));
				end
				checkValue("store address", storeRom[storeBase + seen][23:16], storeAddr);
				checkValue("store data", storeRom[storeBase + seen][15:0], storeData);
				seen++;
			end
			@(negedge clk);
		end
		if (seen != storeNum[t]) begin
			stopWithError($sformatf("test %s halted after %0d of %0d expected stores",
				currentTest, seen, storeNum[t]));
		end
		// Core must stay quiet once halted
		repeat (4) begin
			if (storeValid) begin
				stopWithError($sformatf("test %s stored after halting", currentTest));
			end
			@(negedge clk);
		end
	endtask

	initial begin
		int romBase;
		int storeBase;
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		buildTestTable();
		for (int t = 0; t < numTests; t++) begin
			cycleLimit += 4 * progLen[t] + loopCycles[t] + resetCycles + progLen[t] + 1;
		end
		romBase = 0;
		storeBase = 0;
		for (int t = 0; t < numTests; t++) begin
			runTest(t, romBase, storeBase);
			romBase += progLen[t];
			storeBase += storeNum[t];
		end
		$display("Test OK");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verification
src/cpuPkg.sv
src/cpuAlu.sv
src/regFile.sv
src/dataMem.sv
src/pipeDatapath.sv
src/cpuControl.sv
src/pipeCpu.sv
verification/pipeCpuTb.sv
